/* verification/acq_cases.txt */
# kind  raw_hex  gain  offset  edge(0 rise, 1 fall)  expected_sample
# gain has 14 fractional bits, 16384 is unity; samples and offsets are signed decimal
sw    1fff   16384      0  0      0
sw    0000   16384      0  0   8191
sw    3fff   16384      0  0  -8192
sw    2000   16384      0  0     -1
sw    1f00   16384      0  0    255
sw    1f00   16384   -300  0    -45
sw    1000   16384   -100  0   3995
sw    1000   32767    100  0   8191
sw    0000   32767      0  0   8191
sw    3fff   32767      0  0  -8192
sw    2f00   16384      0  0  -3841
sw    2f00  -16384      0  0   3841
sw    1f00    8192      0  0    127
sw    2f00    8192      0  0  -1921
sw    1f00   16384   8191  0   8191
sw    2f00   16384  -8192  0  -8192
sw    1800   24576     50  0   3120
sw    2800  -32768      0  0   4098
sw    0400  -32768      0  0  -8192
ext   1a00   16384      0  0   1535
ext   2500   12000    -20  1   -959
ext   0000   16384     -1  0   8190
ext   3fff   16384      1  1  -8191
idle  1000   16384      0  0   4095
idle  2000   16384      0  1     -1

/* project.f */
rtl/acq_pkg.sv
rtl/adc_format.sv
rtl/calib_linear.sv
rtl/trig_debounce.sv
rtl/acq_fsm.sv
rtl/acq_top.sv
verification/acq_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the acquisition testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --assert -Wno-fatal --top-module acq_tb -f project.f -o acq_sim; then
  echo "build failed"
  exit 1
fi

sim_out=$(./obj_dir/acq_sim)
sim_rc=$?
echo "$sim_out"
if [ "$sim_rc" -ne 0 ]; then
  echo "simulation exited with status $sim_rc"
  exit 1
fi

if grep -qx "Everything OK" <<< "$sim_out"; then
  exit 0
fi
exit 1

/* verification/acq_tb.sv */
// testbench for the acquisition front end; plays the case file and checks captures and pulses
`default_nettype none

module acq_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import acq_pkg::*;

  localparam int CAP_LEN     = 16;
  localparam int DEB_CYCLES  = 8;
  localparam int CLK_HALF    = 10;
  localparam int DRV_DLY     = 2;
  localparam int RST_CYCLES  = 16;
  // lockout runs out, then at least 10 cycles of stable word before arming
  localparam int HOLD_CYCLES = DEB_CYCLES + 14;
  localparam int IDLE_WAIT   = 40;
  localparam int CASE_BUDGET = CAP_LEN + DEB_CYCLES + 60;
  localparam logic [31:0] SEED = 32'h3aae;
  localparam string CASE_FILE = "verification/acq_cases.txt";
  localparam int KIND_SW   = 0;
  localparam int KIND_EXT  = 1;
  localparam int KIND_IDLE = 2;

  logic adc_clk, top_rst, ext_trg_i, arm_i, sw_trg_i;
  logic [ADC_W-1:0] adc_dat_i;
  trg_edge_t trg_edge_i;
  gain_t cfg_gain_i;
  adc_smp_t cfg_offset_i, smp_o;
  logic smp_vld_o, armed_o, irq_trg_o, irq_stp_o;

  // scoreboard state, monitor side and sequence side kept apart
  adc_smp_t exp_smp = '0;
  int vld_cnt = 0;
  int run_cnt = 0;
  int trg_cnt = 0;
  int stp_cnt = 0;
  int mon_err = 0;
  int chk_err = 0;
  logic vld_prev = 1'b0;
  int cyc_cnt = 0;
  int cyc_limit = 0;
  logic [31:0] rng = SEED;

  // case table
  int kind_q[$];
  logic [ADC_W-1:0] raw_q[$];
  int gain_q[$];
  int off_q[$];
  int edge_q[$];
  int exp_q[$];

  acq_top #(
    .CAP_LEN    (CAP_LEN),
    .DEB_CYCLES (DEB_CYCLES)
  ) i_dut (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .adc_dat_i    (adc_dat_i),
    .ext_trg_i    (ext_trg_i),
    .trg_edge_i   (trg_edge_i),
    .cfg_gain_i   (cfg_gain_i),
    .cfg_offset_i (cfg_offset_i),
    .arm_i        (arm_i),
    .sw_trg_i     (sw_trg_i),
    .smp_o        (smp_o),
    .smp_vld_o    (smp_vld_o),
    .armed_o      (armed_o),
    .irq_trg_o    (irq_trg_o),
    .irq_stp_o    (irq_stp_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_HALF) adc_clk = ~adc_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // n rising edges, then the drive offset
  task automatic step(input int n);
    repeat (n) @(posedge adc_clk);
    #(DRV_DLY);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // formatter rule, then multiply, floor shift, offset and clamp
  function automatic int rule_value(input logic [ADC_W-1:0] raw, input int gain, input int off);
    longint fmt;
    longint val;
    fmt = longint'(raw ^ 14'h1fff);
    if (fmt > 8191) fmt = fmt - 16384;
    val = ((fmt * longint'(gain)) >>> GAIN_FRAC) + longint'(off);
    if (val > longint'(SMP_MAX)) val = longint'(SMP_MAX);
    if (val < longint'(SMP_MIN)) val = longint'(SMP_MIN);
    return int'(val);
  endfunction

  function automatic string kind_name(input int k);
    if (k == KIND_SW) return "sw";
    if (k == KIND_EXT) return "ext";
    return "idle";
  endfunction

  task automatic check_cond(input bit cond, input string what);
    assert (cond) else begin
      $display("FAILED %0t: %s", $time, what);
      chk_err++;
    end
  endtask

  task automatic load_cases();
    int fd;
    int n;
    int gain;
    int off;
    int edge_v;
    int expv;
    logic [ADC_W-1:0] raw;
    logic [63:0] kind_s;
    string line_s;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("could not open case file %s", CASE_FILE);
      return;
    end
    while ($fgets(line_s, fd) != 0) begin
      n = 0;
      // skip column notes
      if (line_s.len() > 0 && line_s[0] != "#") begin
        n = $sscanf(line_s, "%s %h %d %d %d %d", kind_s, raw, gain, off, edge_v, expv);
      end
      if (n == 6) begin
        if (kind_s == "sw") kind_q.push_back(KIND_SW);
        else if (kind_s == "ext") kind_q.push_back(KIND_EXT);
        else kind_q.push_back(KIND_IDLE);
        raw_q.push_back(raw);
        gain_q.push_back(gain);
        off_q.push_back(off);
        edge_q.push_back(edge_v);
        exp_q.push_back(expv);
      end
    end
    $fclose(fd);
  endtask

  // odd number of pin toggles inside 6 cycles, ends on the opposite level
  task automatic bounce_pin();
    int c;
    int toggles;
    toggles = 0;
    for (c = 0; c < 6; c++) begin
      rng = lcg_next(rng);
      if (c == 0 || (c < 5 && rng[16]) || (c == 5 && toggles % 2 == 0)) begin
        ext_trg_i = ~ext_trg_i;
        toggles++;
      end
      step(1);
    end
  endtask

  task automatic check_reset(output bit ok);
    int err0;
    err0 = chk_err;
    check_cond(!smp_vld_o && !armed_o, "smp_vld_o or armed_o high after reset");
    check_cond(!irq_trg_o && !irq_stp_o, "irq pulse high after reset");
    check_cond(smp_o == '0, "smp_o not zero after reset");
    check_cond(i_dut.i_fsm.state_q == ACQ_IDLE, "capture FSM not idle after reset");
    ok = (chk_err == err0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // case player
  //////////////////////////////////////////////////////////////////////

  task automatic run_case(input int idx, output bit ok);
    int err0;
    int calc;
    int v0;
    int r0;
    int t0;
    int s0;
    err0 = mon_err + chk_err;
    calc = rule_value(raw_q[idx], gain_q[idx], off_q[idx]);
    check_cond(calc == exp_q[idx],
               $sformatf("case file expects %0d, rule gives %0d", exp_q[idx], calc));
    exp_smp = adc_smp_t'(calc);
    adc_dat_i = raw_q[idx];
    cfg_gain_i = gain_t'(gain_q[idx]);
    cfg_offset_i = adc_smp_t'(off_q[idx]);
    trg_edge_i = trg_edge_t'(edge_q[idx] != 0);
    // counts cover the unarmed edges below too
    v0 = vld_cnt;
    r0 = run_cnt;
    t0 = trg_cnt;
    s0 = stp_cnt;
    // falling edge cases start low, so the pin rises cleanly while unarmed
    if (kind_q[idx] == KIND_EXT && trg_edge_i == TRG_FALL) begin
      ext_trg_i = 1'b0;
      step(DEB_CYCLES + 4);
    end
    // pin parked opposite to the selected edge, any edge here is unarmed
    if (kind_q[idx] != KIND_SW) ext_trg_i = (trg_edge_i == TRG_FALL);
    step(HOLD_CYCLES);
    if (kind_q[idx] == KIND_IDLE) begin
      sw_trg_i = 1'b1;
      step(1);
      sw_trg_i = 1'b0;
      ext_trg_i = ~ext_trg_i;
      step(IDLE_WAIT);
      check_cond(vld_cnt == v0 && trg_cnt == t0 && stp_cnt == s0,
                 "capture activity without arming");
      check_cond(!armed_o, "armed_o high without arm pulse");
    end else begin
      arm_i = 1'b1;
      step(1);
      arm_i = 1'b0;
      step(1);
      check_cond(armed_o, "armed_o low after arm pulse");
      if (kind_q[idx] == KIND_SW) begin
        sw_trg_i = 1'b1;
        step(1);
        sw_trg_i = 1'b0;
      end else begin
        bounce_pin();
      end
      // end of capture, watchdog covers a missing stop pulse
      while (stp_cnt == s0) step(1);
      step(5);
      check_cond(trg_cnt - t0 == 1, $sformatf("%0d trigger pulses", trg_cnt - t0));
      check_cond(stp_cnt - s0 == 1, $sformatf("%0d stop pulses", stp_cnt - s0));
      check_cond(vld_cnt - v0 == CAP_LEN, $sformatf("%0d valid samples", vld_cnt - v0));
      check_cond(run_cnt - r0 == 1, "valid samples not in one contiguous run");
      check_cond(!armed_o, "armed_o still high after capture");
    end
    ok = (mon_err + chk_err == err0);
  endtask

  // output monitor, samples in the middle of the cycle
  always @(negedge adc_clk) begin
    if (!top_rst) begin
      if (smp_vld_o) begin
        vld_cnt++;
        if (!vld_prev) run_cnt++;
        assert (smp_o == exp_smp) else begin
          $display("FAILED %0t: smp_o is %0d, expected %0d", $time, smp_o, exp_smp);
          mon_err++;
        end
      end
      if (irq_trg_o) trg_cnt++;
      if (irq_stp_o) begin
        stp_cnt++;
        // stop pulse sits in the cycle right after the last sample
        assert (!smp_vld_o && vld_prev) else begin
          $display("FAILED %0t: irq_stp_o not in the cycle after the last sample", $time);
          mon_err++;
        end
      end
    end
    vld_prev = smp_vld_o;
  end

  initial begin : watchdog
    wait (cyc_limit != 0);
    while (cyc_cnt < cyc_limit) begin
      @(posedge adc_clk);
      cyc_cnt++;
    end
    $display("timeout: run did not end within %0d cycles", cyc_limit);
    $display("Something failed");
    $finish;
  end

  initial begin : main_seq
    int i;
    int n_pass;
    int n_fail;
    bit ok;
    n_pass = 0;
    n_fail = 0;
    top_rst = 1'b1;
    adc_dat_i = '0;
    ext_trg_i = 1'b0;
    trg_edge_i = TRG_RISE;
    cfg_gain_i = '0;
    cfg_offset_i = '0;
    arm_i = 1'b0;
    sw_trg_i = 1'b0;
    load_cases();
    if (kind_q.size() == 0) begin
      $display("no usable case line was read, nothing was run");
      $display("Something failed");
    end else begin
      cyc_limit = kind_q.size() * CASE_BUDGET + 100;
      step(RST_CYCLES);
      top_rst = 1'b0;
      step(1);
      check_reset(ok);
      $display("reset: %s", ok ? "pass" : "fail");
      if (ok) n_pass++;
      else n_fail++;
      for (i = 0; i < kind_q.size(); i++) begin
        run_case(i, ok);
        $display("case %0d %s raw %h: %s", i, kind_name(kind_q[i]), raw_q[i],
                 ok ? "pass" : "fail");
        if (ok) n_pass++;
        else n_fail++;
      end
      $display("tests passed %0d failed %0d", n_pass, n_fail);
      if (n_fail == 0 && mon_err + chk_err == 0) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
    end
    $finish;
  end

endmodule : acq_tb

`default_nettype wire

/* rtl/acq_top.sv */
// acquisition front end top level, connects formatter, calibration, trigger debounce and capture FSM
`default_nettype none

module acq_top #(
  parameter int unsigned CAP_LEN    = 16,
  parameter int unsigned DEB_CYCLES = 8
) (
  // clock and reset
  input  logic                       adc_clk,
  input  logic                       top_rst,
  // converter data
  input  logic [acq_pkg::ADC_W-1:0]  adc_dat_i,
  // external trigger pin
  input  logic                       ext_trg_i,
  // static configuration
  input  acq_pkg::trg_edge_t         trg_edge_i,
  input  acq_pkg::gain_t             cfg_gain_i,
  input  acq_pkg::adc_smp_t          cfg_offset_i,
  // software control pulses
  input  logic                       arm_i,
  input  logic                       sw_trg_i,
  // captured samples and status
  output acq_pkg::adc_smp_t          smp_o,
  output logic                       smp_vld_o,
  output logic                       armed_o,
  output logic                       irq_trg_o,
  output logic                       irq_stp_o
);

  import acq_pkg::*;

  // data path between stages
  adc_smp_t fmt_smp;
  adc_smp_t cal_smp;
  // debounced trigger pulses
  logic     trg_pos;
  logic     trg_neg;

  ////////////////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////////////////

  adc_format i_fmt (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .fmt_smp_o (fmt_smp)
  );

  calib_linear i_cal (
    .adc_clk  (adc_clk),
    .top_rst  (top_rst),
    .smp_i    (fmt_smp),
    .gain_i   (cfg_gain_i),
    .offset_i (cfg_offset_i),
    .smp_o    (cal_smp)
  );

  ////////////////////////////////////////////////////////////////////////
  // trigger and capture control
  ////////////////////////////////////////////////////////////////////////

  trig_debounce #(
    .DEB_CYCLES (DEB_CYCLES)
  ) i_deb (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .pin_i     (ext_trg_i),
    .trg_pos_o (trg_pos),
    .trg_neg_o (trg_neg)
  );

  acq_fsm #(
    .CAP_LEN (CAP_LEN)
  ) i_fsm (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .arm_i      (arm_i),
    .sw_trg_i   (sw_trg_i),
    .trg_pos_i  (trg_pos),
    .trg_neg_i  (trg_neg),
    .trg_edge_i (trg_edge_i),
    .smp_i      (cal_smp),
    .smp_o      (smp_o),
    .smp_vld_o  (smp_vld_o),
    .armed_o    (armed_o),
    .irq_trg_o  (irq_trg_o),
    .irq_stp_o  (irq_stp_o)
  );

endmodule : acq_top

`default_nettype wire

/* rtl/acq_fsm.sv */
// oscilloscope style capture control: arm, wait for trigger, emit CAP_LEN samples, stop pulse
`default_nettype none

module acq_fsm #(
  parameter int unsigned CAP_LEN = 16
) (
  // clock and reset
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // control pulses
  input  logic                 arm_i,
  input  logic                 sw_trg_i,
  // debounced external edges
  input  logic                 trg_pos_i,
  input  logic                 trg_neg_i,
  input  acq_pkg::trg_edge_t   trg_edge_i,
  // calibrated samples
  input  acq_pkg::adc_smp_t    smp_i,
  // captured stream and status
  output acq_pkg::adc_smp_t    smp_o,
  output logic                 smp_vld_o,
  output logic                 armed_o,
  output logic                 irq_trg_o,
  output logic                 irq_stp_o
);

  import acq_pkg::*;

  localparam int unsigned CNT_W = (CAP_LEN > 1) ? $clog2(CAP_LEN) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CAP_LEN - 1);

  acq_state_t       state_q;
  acq_state_t       state_d;
  logic [CNT_W-1:0] cnt_q;
  logic             trg_sel;
  logic             trg_hit;
  logic             cap_end;

  ////////////////////////////////////////////////////////////////////////
  // trigger select
  ////////////////////////////////////////////////////////////////////////

  // external edge picked by config, software trigger always counts
  assign trg_sel = (trg_edge_i == TRG_RISE) ? trg_pos_i : trg_neg_i;
  assign trg_hit = sw_trg_i | trg_sel;
  // last capture cycle
  assign cap_end = (state_q == ACQ_CAPTURE) && (cnt_q == CNT_LAST);

  ////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ACQ_IDLE: begin
        if (arm_i) state_d = ACQ_ARMED;
      end
      ACQ_ARMED: begin
        if (trg_hit) state_d = ACQ_CAPTURE;
      end
      ACQ_CAPTURE: begin
        if (cap_end) state_d = ACQ_IDLE;
      end
      default: state_d = ACQ_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////
  // state, counter and registered outputs
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      state_q   <= ACQ_IDLE;
      cnt_q     <= '0;
      smp_o     <= '0;
      smp_vld_o <= 1'b0;
      armed_o   <= 1'b0;
      irq_trg_o <= 1'b0;
      irq_stp_o <= 1'b0;
    end else begin
      state_q <= state_d;
      // counts samples already emitted
      if (state_q == ACQ_CAPTURE) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q <= '0;
      end
      // outputs follow next state, so first sample is one cycle after trigger
      smp_vld_o <= (state_d == ACQ_CAPTURE);
      smp_o     <= (state_d == ACQ_CAPTURE) ? smp_i : '0;
      armed_o   <= (state_d == ACQ_ARMED);
      irq_trg_o <= (state_q == ACQ_ARMED) && trg_hit;
      irq_stp_o <= cap_end;
    end
  end

endmodule : acq_fsm

`default_nettype wire

/* rtl/trig_debounce.sv */
// external trigger pin debounce: two stage synchronizer, lockout timer, rise and fall pulses
`default_nettype none

module trig_debounce #(
  parameter int unsigned DEB_CYCLES = 8
) (
  // clock and reset
  input  logic  adc_clk,
  input  logic  top_rst,
  // asynchronous pin
  input  logic  pin_i,
  // one cycle edge pulses
  output logic  trg_pos_o,
  output logic  trg_neg_o
);

  // counter must hold DEB_CYCLES itself
  localparam int unsigned CNT_W = $clog2(DEB_CYCLES + 1);

  logic [1:0]       sync_q;
  logic             lvl_q;
  logic [CNT_W-1:0] cnt_q;
  logic             chg;

  ////////////////////////////////////////////////////////////////////////
  // synchronizer
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], pin_i};
    end
  end

  // change only counts once lockout has run out
  assign chg = (sync_q[1] != lvl_q) && (cnt_q == '0);

  ////////////////////////////////////////////////////////////////////////
  // lockout timer and edge detect
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      lvl_q     <= 1'b0;
      cnt_q     <= '0;
      trg_pos_o <= 1'b0;
      trg_neg_o <= 1'b0;
    end else begin
      trg_pos_o <= chg &  sync_q[1];
      trg_neg_o <= chg & ~sync_q[1];
      if (chg) begin
        // accept new level, hold off bounces
        lvl_q <= sync_q[1];
        cnt_q <= CNT_W'(DEB_CYCLES);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule : trig_debounce

`default_nettype wire

/* rtl/calib_linear.sv */
// linear calibration stage: gain multiply, fixed point shift, offset add and saturation, one cycle
`default_nettype none

module calib_linear (
  // clock and reset
  input  logic               adc_clk,
  input  logic               top_rst,
  // sample in
  input  acq_pkg::adc_smp_t  smp_i,
  // static configuration
  input  acq_pkg::gain_t     gain_i,
  input  acq_pkg::adc_smp_t  offset_i,
  // calibrated sample out
  output acq_pkg::adc_smp_t  smp_o
);

  import acq_pkg::*;

  // full width product, one extra bit for the offset sum
  localparam int unsigned MUL_W = ADC_W + GAIN_W;
  localparam int unsigned SUM_W = MUL_W + 1;

  logic signed [MUL_W-1:0] mul;
  logic signed [MUL_W-1:0] shf;
  logic signed [SUM_W-1:0] sum;
  adc_smp_t                sat;

  ////////////////////////////////////////////////////////////////////////
  // arithmetic
  ////////////////////////////////////////////////////////////////////////

  always_comb begin
    // signed operands, sign extended to product width
    mul = smp_i * gain_i;
    // drop fractional gain bits, keeps sign
    shf = mul >>> GAIN_FRAC;
    // offset sign extended to full sum width
    sum = SUM_W'(shf) + SUM_W'(offset_i);
    // clamp into sample range
    if (sum > SUM_W'(SMP_MAX)) begin
      sat = SMP_MAX;
    end else if (sum < SUM_W'(SMP_MIN)) begin
      sat = SMP_MIN;
    end else begin
      sat = adc_smp_t'(sum);
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      smp_o <= '0;
    end else begin
      smp_o <= sat;
    end
  end

endmodule : calib_linear

`default_nettype wire

/* rtl/adc_format.sv */
// ADC input register, converts inverted offset binary from the converter to two's complement
`default_nettype none

module adc_format (
  // clock and reset
  input  logic                       adc_clk,
  input  logic                       top_rst,
  // raw converter word
  input  logic [acq_pkg::ADC_W-1:0]  adc_dat_i,
  // signed sample
  output acq_pkg::adc_smp_t          fmt_smp_o
);

  import acq_pkg::*;

  ////////////////////////////////////////////////////////////////////////
  // code conversion
  ////////////////////////////////////////////////////////////////////////

  // msb kept as is, lower bits flipped
  // inverted offset binary becomes plain two's complement this way
  adc_smp_t fmt_d;

  always_comb begin
    fmt_d = {adc_dat_i[ADC_W-1], ~adc_dat_i[ADC_W-2:0]};
  end

  ////////////////////////////////////////////////////////////////////////
  // input register
  ////////////////////////////////////////////////////////////////////////

  // one cycle latency, new sample every clock
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      fmt_smp_o <= '0;
    end else begin
      fmt_smp_o <= fmt_d;
    end
  end

endmodule : adc_format

`default_nettype wire

/* rtl/acq_pkg.sv */
// shared widths, sample and gain types and enums, imported by the acquisition RTL and testbench
`default_nettype none

package acq_pkg;

  //////////////////////////////////////////////////////////////////////
  // sample data
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ADC_W = 14;

  typedef logic signed [ADC_W-1:0] adc_smp_t;

  // saturation limits, +8191 / -8192
  localparam adc_smp_t SMP_MAX = {1'b0, {(ADC_W-1){1'b1}}};
  localparam adc_smp_t SMP_MIN = {1'b1, {(ADC_W-1){1'b0}}};

  //////////////////////////////////////////////////////////////////////
  // calibration gain, unity is 1 << GAIN_FRAC
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned GAIN_W    = 16;
  localparam int unsigned GAIN_FRAC = 14;

  typedef logic signed [GAIN_W-1:0] gain_t;

  // capture control states
  typedef enum logic [1:0] {
    ACQ_IDLE    = 2'd0,
    ACQ_ARMED   = 2'd1,
    ACQ_CAPTURE = 2'd2
  } acq_state_t;

  // which debounced edge fires the trigger
  typedef enum logic {
    TRG_RISE = 1'b0,
    TRG_FALL = 1'b1
  } trg_edge_t;

endpackage : acq_pkg

`default_nettype wire
